// File: Bender.yml
package:
  name: mipsCore

sources:
  - design/mipsPkg.sv
  - design/mipsFetch.sv
  - design/mipsDecode.sv
  - design/mipsHazard.sv
  - design/mipsExecute.sv
  - design/mipsMemory.sv
  - design/mipsCore.sv
  - target: test
    files:
      - sim/mipsCoreTb.sv

// File: design/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic                        clk,
    input  logic                        i_arstN,
    input  logic                        i_load,
    input  logic                        i_instrWe,
    input  logic [mipsPkg::IMEM_AW-1:0] i_instrAddr,
    input  logic [31:0]                 i_instrData,
    output mipsPkg::wbPort_t            o_wb,      // every register write in order
    output logic [15:0]                 o_pcLsb,
    output logic                        o_end
);
    import mipsPkg::*;

    ifId_t       ifId;
    idEx_t       idEx;
    exMem_t      exMem;
    ctrl_t       ctrl;        // raw decode of the IF/ID word
    fwdSel_e     fwdA;
    fwdSel_e     fwdB;
    logic        stall;
    logic        halted;
    logic        redirect;
    logic [31:0] target;

    mipsFetch fetchInst (
        .clk         (clk),
        .i_arstN     (i_arstN),
        .i_load      (i_load),
        .i_instrWe   (i_instrWe),
        .i_instrAddr (i_instrAddr),
        .i_instrData (i_instrData),
        .i_stall     (stall),
        .i_halted    (halted),
        .i_redirect  (redirect),
        .i_target    (target),
        .o_ifId      (ifId),
        .o_pcLsb     (o_pcLsb)
    );

    // o_wb doubles as the internal writeback net
    mipsDecode decodeInst (
        .clk        (clk),
        .i_arstN    (i_arstN),
        .i_load     (i_load),
        .i_stall    (stall),
        .i_ifId     (ifId),
        .i_wb       (o_wb),
        .o_idEx     (idEx),
        .o_redirect (redirect),
        .o_target   (target),
        .o_ctrl     (ctrl),
        .o_halted   (halted)
    );

    mipsHazard hazardInst (
        .i_ifId  (ifId),
        .i_ctrl  (ctrl),
        .i_idEx  (idEx),
        .i_exMem (exMem),
        .i_wb    (o_wb),
        .o_stall (stall),
        .o_fwdA  (fwdA),
        .o_fwdB  (fwdB)
    );

    mipsExecute executeInst (
        .clk     (clk),
        .i_arstN (i_arstN),
        .i_load  (i_load),
        .i_idEx  (idEx),
        .i_fwdA  (fwdA),
        .i_fwdB  (fwdB),
        .i_wb    (o_wb),
        .o_exMem (exMem)
    );

    mipsMemory memoryInst (
        .clk     (clk),
        .i_arstN (i_arstN),
        .i_load  (i_load),
        .i_exMem (exMem),
        .o_wb    (o_wb),
        .o_end   (o_end)
    );

endmodule

// File: design/mipsDecode.sv
`timescale 1ns/1ps

module mipsDecode (
    input  logic             clk,
    input  logic             i_arstN,
    input  logic             i_load,
    input  logic             i_stall,
    input  mipsPkg::ifId_t   i_ifId,
    input  mipsPkg::wbPort_t i_wb,
    output mipsPkg::idEx_t   o_idEx,
    output logic             o_redirect,
    output logic [31:0]      o_target,
    output mipsPkg::ctrl_t   o_ctrl,      // raw decode for hazard unit
    output logic             o_halted
);
    import mipsPkg::*;

    logic [31:0] regs [NUM_REGS];
    instr_u      instr;
    ctrl_t       ctrl;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] immExt;
    logic [31:0] pcPlus4;
    logic        taken;
    logic        issue;     // live instruction leaves decode now
    logic        haltedQ;

    assign instr = i_ifId.instr;
    assign rs    = instr.rType.rs;
    assign rt    = instr.rType.rt;

    always_comb begin
        ctrl = '0;
        case (instr.rType.opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                case (instr.rType.funct)
                    F_ADDU:  ctrl.aluOp = ALU_ADD;
                    F_SUBU:  ctrl.aluOp = ALU_SUB;
                    F_AND:   ctrl.aluOp = ALU_AND;
                    F_OR:    ctrl.aluOp = ALU_OR;
                    F_XOR:   ctrl.aluOp = ALU_XOR;
                    F_SLT:   ctrl.aluOp = ALU_SLT;
                    F_SLL:   ctrl.aluOp = ALU_SLL;
                    F_SRL:   ctrl.aluOp = ALU_SRL;
                    default: ctrl.regWrite = 1'b0;   // unknown funct is a nop
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                case (instr.iType.opcode)
                    OP_ANDI: ctrl.aluOp = ALU_AND;
                    OP_ORI:  ctrl.aluOp = ALU_OR;
                    OP_LUI:  ctrl.aluOp = ALU_LUI;
                    default: ctrl.aluOp = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.mem2Reg   = 1'b1;
                ctrl.aluSrcImm = 1'b1;   // base + offset
            end
            OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_BEQ:  ctrl.branch = 1'b1;
            OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
            end
            OP_J:    ctrl.jump = 1'b1;
            OP_HALT: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // register file cleared for each new program and r0 never written
    always_ff @(posedge clk) begin
        if (i_load) begin
            regs <= '{default: '0};
        end else if (i_wb.regWrite && i_wb.addr != '0) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // write-first bypass of the writeback port
    assign rsVal = (i_wb.regWrite && i_wb.addr == rs) ? i_wb.data : regs[rs];
    assign rtVal = (i_wb.regWrite && i_wb.addr == rt) ? i_wb.data : regs[rt];

    // andi/ori zero extend and the rest sign extend
    assign immExt = (instr.iType.opcode inside {OP_ANDI, OP_ORI}) ?
                    {16'h0, instr.iType.imm} : {{16{instr.iType.imm[15]}}, instr.iType.imm};

    assign pcPlus4  = i_ifId.pc + 32'd4;
    assign taken    = ctrl.jump || (ctrl.branch && ((rsVal == rtVal) != ctrl.branchNe));
    assign o_target = ctrl.jump ? {pcPlus4[31:28], instr.jType.target, 2'b00}
                                : pcPlus4 + {immExt[29:0], 2'b00};

    assign issue      = i_ifId.valid && !haltedQ && !i_stall;
    assign o_redirect = issue && taken;
    assign o_halted   = haltedQ || (issue && ctrl.halt);   // fetch stops on the halt edge
    assign o_ctrl     = ctrl;

    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_idEx  <= '0;
            haltedQ <= 1'b0;
        end else if (i_load) begin
            o_idEx  <= '0;
            haltedQ <= 1'b0;
        end else begin
            haltedQ <= o_halted;   // sticky until next load
            if (issue) begin
                o_idEx.ctrl  <= ctrl;
                o_idEx.rs    <= rs;
                o_idEx.rt    <= rt;
                o_idEx.dest  <= ctrl.regDst ? instr.rType.rd : rt;
                o_idEx.opA   <= rsVal;
                o_idEx.opB   <= rtVal;
                o_idEx.imm   <= immExt;
                o_idEx.shamt <= instr.rType.shamt;
            end else begin
                o_idEx <= '0;      // bubble on stall, halt or empty slot
            end
        end
    end

    // a $zero source carries zero into execute
    zeroRegReadsZero: assert property (@(posedge clk) disable iff (!i_arstN)
        (o_idEx.rs != '0 || o_idEx.opA == '0) && (o_idEx.rt != '0 || o_idEx.opB == '0));

endmodule

// File: design/mipsExecute.sv
`timescale 1ns/1ps

module mipsExecute (
    input  logic             clk,
    input  logic             i_arstN,
    input  logic             i_load,
    input  mipsPkg::idEx_t   i_idEx,
    input  mipsPkg::fwdSel_e i_fwdA,
    input  mipsPkg::fwdSel_e i_fwdB,
    input  mipsPkg::wbPort_t i_wb,
    output mipsPkg::exMem_t  o_exMem
);
    import mipsPkg::*;

    logic [31:0] opA;
    logic [31:0] opB;      // forwarded rt, also store data
    logic [31:0] aluB;
    logic [31:0] result;

    function automatic logic [31:0] fwdMux(input fwdSel_e sel, input logic [31:0] regVal,
                                           input logic [31:0] memVal,
                                           input logic [31:0] wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA  = fwdMux(i_fwdA, i_idEx.opA, o_exMem.result, i_wb.data);
    assign opB  = fwdMux(i_fwdB, i_idEx.opB, o_exMem.result, i_wb.data);
    assign aluB = i_idEx.ctrl.aluSrcImm ? i_idEx.imm : opB;

    always_comb begin
        case (i_idEx.ctrl.aluOp)
            ALU_ADD: result = opA + aluB;
            ALU_SUB: result = opA - aluB;
            ALU_AND: result = opA & aluB;
            ALU_OR:  result = opA | aluB;
            ALU_XOR: result = opA ^ aluB;
            ALU_SLT: result = {31'd0, $signed(opA) < $signed(aluB)};
            ALU_SLL: result = aluB << i_idEx.shamt;   // shifts act on rt
            ALU_SRL: result = aluB >> i_idEx.shamt;
            ALU_LUI: result = {aluB[15:0], 16'h0};
            default: result = opA + aluB;
        endcase
    end

    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_exMem <= '0;
        end else if (i_load) begin
            o_exMem <= '0;
        end else begin
            o_exMem.ctrl      <= i_idEx.ctrl;
            o_exMem.dest      <= i_idEx.dest;
            o_exMem.result    <= result;   // also the data address
            o_exMem.storeData <= opB;
        end
    end

    // hazard unit only forwards from a stage that really writes
    fwdFromWriter: assert property (@(posedge clk) disable iff (!i_arstN)
        ((i_fwdA == FWD_MEM || i_fwdB == FWD_MEM) |-> o_exMem.ctrl.regWrite) and
        ((i_fwdA == FWD_WB || i_fwdB == FWD_WB) |-> i_wb.regWrite));

endmodule

// File: design/mipsFetch.sv
`timescale 1ns/1ps

module mipsFetch (
    input  logic                        clk,
    input  logic                        i_arstN,
    input  logic                        i_load,       // core held while imem is filled
    input  logic                        i_instrWe,
    input  logic [mipsPkg::IMEM_AW-1:0] i_instrAddr,
    input  logic [31:0]                 i_instrData,
    input  logic                        i_stall,
    input  logic                        i_halted,
    input  logic                        i_redirect,   // taken branch or jump in decode
    input  logic [31:0]                 i_target,
    output mipsPkg::ifId_t              o_ifId,
    output logic [15:0]                 o_pcLsb
);
    import mipsPkg::*;

    logic [31:0] imem [IMEM_DEPTH];
    logic [31:0] pc;
    logic [31:0] instr;

    // load port
    always_ff @(posedge clk) begin
        if (i_load && i_instrWe) begin
            imem[i_instrAddr] <= i_instrData;
        end
    end

    assign instr   = imem[pc[IMEM_AW+1:2]];   // async read by word address
    assign o_pcLsb = pc[15:0];

    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pc     <= '0;
            o_ifId <= '0;
        end else if (i_load) begin
            pc     <= '0;      // run starts at address 0
            o_ifId <= '0;
        end else if (i_redirect) begin
            pc           <= i_target;
            o_ifId.valid <= 1'b0;     // squash the fall-through fetch
        end else if (i_halted) begin
            o_ifId.valid <= 1'b0;     // pc frozen from here on
        end else if (!i_stall) begin
            pc           <= pc + 32'd4;
            o_ifId.instr <= instr;
            o_ifId.pc    <= pc;
            o_ifId.valid <= 1'b1;
        end
    end

    // imem only changes while the core is held
    instrWriteInLoad: assert property (@(posedge clk) disable iff (!i_arstN)
        i_instrWe |-> i_load);

endmodule

// File: design/mipsHazard.sv
`timescale 1ns/1ps

module mipsHazard (
    input  mipsPkg::ifId_t   i_ifId,
    input  mipsPkg::ctrl_t   i_ctrl,
    input  mipsPkg::idEx_t   i_idEx,
    input  mipsPkg::exMem_t  i_exMem,
    input  mipsPkg::wbPort_t i_wb,
    output logic             o_stall,
    output mipsPkg::fwdSel_e o_fwdA,
    output mipsPkg::fwdSel_e o_fwdB
);
    import mipsPkg::*;

    logic [4:0] rs;
    logic [4:0] rt;
    logic       useRs;
    logic       useRt;
    logic       hitEx;      // EX dest matches a decode source
    logic       hitMem;
    logic       loadUse;
    logic       branchWait;

    // MEM result is younger so it wins over WB
    function automatic fwdSel_e fwdPick(input logic [4:0] src, input exMem_t mem,
                                        input wbPort_t wb);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (mem.ctrl.regWrite && mem.dest == src) begin
            return FWD_MEM;
        end
        if (wb.regWrite && wb.addr == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign rs    = i_ifId.instr.rType.rs;
    assign rt    = i_ifId.instr.rType.rt;
    assign useRs = i_ifId.valid && !(i_ctrl.jump || i_ctrl.halt);
    assign useRt = i_ifId.valid && (i_ctrl.regDst || i_ctrl.memWrite || i_ctrl.branch);

    assign hitEx  = (i_idEx.dest != '0) &&
                    ((useRs && i_idEx.dest == rs) || (useRt && i_idEx.dest == rt));
    assign hitMem = (i_exMem.dest != '0) &&
                    ((useRs && i_exMem.dest == rs) || (useRt && i_exMem.dest == rt));

    assign loadUse    = i_idEx.ctrl.memRead && hitEx;
    // branches compare in decode so they wait out EX and MEM producers
    assign branchWait = i_ctrl.branch &&
                        ((i_idEx.ctrl.regWrite && hitEx) || (i_exMem.ctrl.regWrite && hitMem));
    assign o_stall    = loadUse || branchWait;

    assign o_fwdA = fwdPick(i_idEx.rs, i_exMem, i_wb);
    assign o_fwdB = fwdPick(i_idEx.rt, i_exMem, i_wb);

endmodule

// File: design/mipsMemory.sv
`timescale 1ns/1ps

module mipsMemory (
    input  logic             clk,
    input  logic             i_arstN,
    input  logic             i_load,
    input  mipsPkg::exMem_t  i_exMem,
    output mipsPkg::wbPort_t o_wb,
    output logic             o_end
);
    import mipsPkg::*;

    logic [31:0]        dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] addr;
    wbPort_t            wbQ;        // alu side of MEM/WB
    logic               mem2RegQ;
    logic [31:0]        loadQ;      // read data, lands with MEM/WB

    assign addr = i_exMem.result[DMEM_AW+1:2];   // word index, bits 7:2

    // data memory with synchronous read
    always_ff @(posedge clk) begin
        if (i_load) begin
            dmem <= '{default: '0};   // fresh memory per program
        end else if (i_exMem.ctrl.memWrite) begin
            dmem[addr] <= i_exMem.storeData;
        end
        loadQ <= dmem[addr];
    end

    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            wbQ      <= '0;
            mem2RegQ <= 1'b0;
            o_end    <= 1'b0;
        end else if (i_load) begin
            wbQ      <= '0;
            mem2RegQ <= 1'b0;
            o_end    <= 1'b0;
        end else begin
            wbQ.regWrite <= i_exMem.ctrl.regWrite && i_exMem.dest != '0;   // $zero never shows
            wbQ.addr     <= i_exMem.dest;
            wbQ.data     <= i_exMem.result;
            mem2RegQ     <= i_exMem.ctrl.mem2Reg;
            o_end        <= o_end || i_exMem.ctrl.halt;   // halt has reached writeback
        end
    end

    assign o_wb.regWrite = wbQ.regWrite;
    assign o_wb.addr     = wbQ.addr;
    assign o_wb.data     = mem2RegQ ? loadQ : wbQ.data;

    // decoder never asks for both
    noReadWithWrite: assert property (@(posedge clk) disable iff (!i_arstN)
        !(i_exMem.ctrl.memRead && i_exMem.ctrl.memWrite));

    // only bubbles follow halt down the pipe
    quietAfterEnd: assert property (@(posedge clk) disable iff (!i_arstN)
        o_end |-> !o_wb.regWrite);

endmodule

// File: design/mipsPkg.sv
package mipsPkg;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam int NUM_REGS   = 32;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f   // all ones
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } aluOp_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,    // EX/MEM result
        FWD_WB      // writeback port
    } fwdSel_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } rType_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iType_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] target;   // word index inside the 256MB region
    } jType_t;

    // one fetched word, three field layouts
    typedef union packed {
        rType_t rType;
        iType_t iType;
        jType_t jType;
    } instr_u;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   mem2Reg;     // wb takes load data
        logic   aluSrcImm;   // alu B from immediate
        logic   regDst;      // dest is rd, else rt
        logic   branch;
        logic   branchNe;    // bne flavour of branch
        logic   jump;
        logic   halt;
        aluOp_e aluOp;
    } ctrl_t;

    typedef struct packed {
        instr_u      instr;
        logic [31:0] pc;
        logic        valid;
    } ifId_t;

    typedef struct packed {
        ctrl_t       ctrl;    // all zero is a bubble
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] imm;     // already extended
        logic [4:0]  shamt;
    } idEx_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [4:0]  dest;
        logic [31:0] result;
        logic [31:0] storeData;
    } exMem_t;

    typedef struct packed {
        logic        regWrite;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbPort_t;

endpackage

// File: mipsCore.f
design/mipsPkg.sv
design/mipsFetch.sv
design/mipsDecode.sv
design/mipsHazard.sv
design/mipsExecute.sv
design/mipsMemory.sv
design/mipsCore.sv
sim/mipsCoreTb.sv

// File: sim/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
    import mipsPkg::*;

    logic                clk;
    logic                i_arstN;
    logic                i_load;
    logic                i_instrWe;
    logic [IMEM_AW-1:0]  i_instrAddr;
    logic [31:0]         i_instrData;
    wbPort_t             o_wb;
    logic [15:0]         o_pcLsb;
    logic                o_end;

    logic [31:0] progMem [IMEM_DEPTH];   // program image used by loader and model
    int          progLen;
    wbPort_t     expQ [$];               // expected writes in program order
    wbPort_t     expWrite;
    int          seed;
    int          errorCount;
    int          passCount;
    int          failCount;
    int          cycleCount;
    int          cycleLimit;

    mipsCore i_dut (
        .clk         (clk),
        .i_arstN     (i_arstN),
        .i_load      (i_load),
        .i_instrWe   (i_instrWe),
        .i_instrAddr (i_instrAddr),
        .i_instrData (i_instrData),
        .o_wb        (o_wb),
        .o_pcLsb     (o_pcLsb),
        .o_end       (o_end)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    // instruction encoders take operands in assembly order
    function automatic logic [31:0] rtypeWord(funct_e fn, int rd, int rs, int rt, int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] itypeWord(opcode_e op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jumpWord(int idx);
        return {OP_J, 26'(idx)};
    endfunction

    // ISA model fills expQ and returns the executed count incl. halt
    function automatic int refRun();
        logic [31:0] regs [NUM_REGS];
        logic [31:0] dmem [DMEM_DEPTH];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [4:0]  dst;
        logic        wr;
        int          steps;
        foreach (regs[k]) regs[k] = '0;
        foreach (dmem[k]) dmem[k] = '0;   // each program sees fresh memory
        expQ.delete();
        pc    = '0;
        steps = 0;
        while (steps < 1000) begin
            ir   = progMem[pc[IMEM_AW+1:2]];
            a    = regs[ir[25:21]];
            b    = regs[ir[20:16]];
            sext = {{16{ir[15]}}, ir[15:0]};
            zext = {16'h0, ir[15:0]};
            steps++;
            if (ir[31:26] == OP_HALT) break;
            npc = pc + 32'd4;
            wr  = 1'b1;
            dst = ir[20:16];   // rt unless R-type
            res = '0;
            case (ir[31:26])
                OP_RTYPE: begin
                    dst = ir[15:11];
                    case (ir[5:0])
                        F_ADDU:  res = a + b;
                        F_SUBU:  res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_XOR:   res = a ^ b;
                        F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F_SLL:   res = b << ir[10:6];
                        F_SRL:   res = b >> ir[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + sext;
                OP_ANDI:  res = a & zext;
                OP_ORI:   res = a | zext;
                OP_LUI:   res = {ir[15:0], 16'h0};
                OP_LW:    res = dmem[(a + sext) >> 2 & 32'(DMEM_DEPTH - 1)];
                OP_SW: begin
                    dmem[(a + sext) >> 2 & 32'(DMEM_DEPTH - 1)] = b;
                    wr = 1'b0;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) npc = pc + 32'd4 + (sext << 2);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b) npc = pc + 32'd4 + (sext << 2);
                end
                OP_J: begin
                    wr  = 1'b0;
                    npc = {npc[31:28], ir[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin   // $zero writes are invisible
                regs[dst] = res;
                expQ.push_back('{regWrite: 1'b1, addr: dst, data: res});
            end
            pc = npc;
        end
        return steps;
    endfunction

    task automatic clearProgram();
        progLen = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        progMem[progLen] = word;
        progLen++;
    endtask

    task automatic loadProgram();
        int k;
        @(posedge clk);
        #1;
        i_load = 1'b1;
        for (k = 0; k < IMEM_DEPTH; k++) begin
            i_instrWe   = 1'b1;
            i_instrAddr = IMEM_AW'(k);
            i_instrData = progMem[k];
            @(posedge clk);
            #1;
        end
        i_instrWe = 1'b0;
        @(negedge clk);
        assert (!o_end && !o_wb.regWrite && o_pcLsb == '0) else begin
            $display("load did not clear o_end, writeback or PC at %0t", $time);
            errorCount++;
        end
        @(posedge clk);
        #1;
        i_load = 1'b0;   // run starts on the next edge
    endtask

    task automatic runTest(input string name);
        int k;
        int steps;
        int errorsBefore;
        int nWrites;
        // unused words hold address-dependent ori that is never reached
        for (k = progLen; k < IMEM_DEPTH; k++) begin
            progMem[k] = itypeWord(OP_ORI, k % 31 + 1, 0, k);
        end
        steps        = refRun();
        nWrites      = expQ.size();
        cycleLimit  += 6 * steps + 20 + IMEM_DEPTH + 8;
        errorsBefore = errorCount;
        loadProgram();
        do @(negedge clk); while (!o_end);
        repeat (4) begin
            @(negedge clk);
            assert (o_end) else begin
                $display("o_end dropped after HALT retired at %0t", $time);
                errorCount++;
            end
        end
        assert (expQ.size() == 0) else begin
            $display("%0d expected register writes never appeared", expQ.size());
            errorCount++;
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %s: passed, %0d instructions, %0d writes", name, steps, nWrites);
        end else begin
            failCount++;
            $display("test %s: failed, %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic buildRandom(input int len);
        int k;
        int kind;
        int rd;
        int rs;
        int rt;
        int imm;
        clearProgram();
        for (k = 0; k < len; k++) begin
            kind = $unsigned($random(seed)) % 14;
            rd   = $unsigned($random(seed)) % 8;   // few regs give many dependencies
            rs   = $unsigned($random(seed)) % 8;
            rt   = $unsigned($random(seed)) % 8;
            imm  = $random(seed);
            case (kind)
                0:  emit(rtypeWord(F_ADDU, rd, rs, rt, 0));
                1:  emit(rtypeWord(F_SUBU, rd, rs, rt, 0));
                2:  emit(rtypeWord(F_AND, rd, rs, rt, 0));
                3:  emit(rtypeWord(F_OR, rd, rs, rt, 0));
                4:  emit(rtypeWord(F_XOR, rd, rs, rt, 0));
                5:  emit(rtypeWord(F_SLT, rd, rs, rt, 0));
                6:  emit(rtypeWord(F_SLL, rd, 0, rt, imm & 31));
                7:  emit(rtypeWord(F_SRL, rd, 0, rt, imm & 31));
                8:  emit(itypeWord(OP_ADDIU, rd, rs, imm));
                9:  emit(itypeWord(OP_ANDI, rd, rs, imm));
                10: emit(itypeWord(OP_ORI, rd, rs, imm));
                11: emit(itypeWord(OP_LUI, rd, 0, imm));
                12: emit(itypeWord(OP_LW, rd, 0, (imm & 15) * 4));   // small window so loads hit stores
                default: emit(itypeWord(OP_SW, rt, 0, (imm & 15) * 4));
            endcase
        end
        emit({OP_HALT, 26'd0});
    endtask

    // checks each o_wb write against the head of expQ
    always @(negedge clk) begin
        if (o_wb.regWrite) begin
            assert (expQ.size() > 0) else begin
                $display("extra register write to r%0d at %0t, none expected", o_wb.addr, $time);
                errorCount++;
            end
            if (expQ.size() > 0) begin
                expWrite = expQ.pop_front();
                assert (o_wb.addr === expWrite.addr && o_wb.data === expWrite.data) else begin
                    $display("ERROR %0t: wb r%0d = %08h, expected r%0d = %08h", $time,
                             o_wb.addr, o_wb.data, expWrite.addr, expWrite.data);
                    errorCount++;
                end
            end
        end
    end

    // watchdog whose limit grows as each test is queued
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run exceeded %0d cycles without HALT retiring", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        seed        = 51294;
        errorCount  = 0;
        passCount   = 0;
        failCount   = 0;
        cycleCount  = 0;
        cycleLimit  = 30;      // reset plus slack
        i_arstN     = 1'b0;
        i_load      = 1'b0;
        i_instrWe   = 1'b0;
        i_instrAddr = '0;
        i_instrData = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (!o_wb.regWrite && !o_end && o_pcLsb == '0) else begin
            $display("outputs not cleared by reset at %0t", $time);
            errorCount++;
        end
        @(posedge clk);
        #1;
        i_arstN = 1'b1;

        // forwarding from MEM and WB
        clearProgram();
        emit(itypeWord(OP_ADDIU, 1, 0, 5));
        emit(itypeWord(OP_ADDIU, 2, 1, -3));
        emit(rtypeWord(F_ADDU, 3, 1, 2, 0));
        emit(rtypeWord(F_SUBU, 4, 3, 1, 0));
        emit(rtypeWord(F_SLL, 5, 0, 4, 4));
        emit(rtypeWord(F_SRL, 6, 0, 5, 2));
        emit(rtypeWord(F_SLT, 7, 6, 5, 0));
        emit(rtypeWord(F_SLT, 8, 5, 6, 0));
        emit(itypeWord(OP_LUI, 9, 0, 'h8001));
        emit(itypeWord(OP_ORI, 9, 9, 'h1234));
        emit(rtypeWord(F_XOR, 10, 9, 5, 0));
        emit(rtypeWord(F_AND, 11, 10, 9, 0));
        emit(rtypeWord(F_OR, 12, 11, 1, 0));
        emit(itypeWord(OP_ADDIU, 13, 0, -1));
        emit(rtypeWord(F_SLT, 14, 13, 0, 0));     // signed compare
        emit(itypeWord(OP_ANDI, 15, 13, 'hff00));
        emit({OP_HALT, 26'd0});
        runTest("dependent arithmetic");

        // stores, loads and load-use stalls
        clearProgram();
        emit(itypeWord(OP_ADDIU, 1, 0, 'h40));
        emit(itypeWord(OP_ADDIU, 2, 0, 77));
        emit(itypeWord(OP_SW, 2, 1, 0));
        emit(itypeWord(OP_SW, 1, 1, 4));
        emit(itypeWord(OP_LW, 3, 1, 0));
        emit(rtypeWord(F_ADDU, 4, 3, 3, 0));      // uses load at once
        emit(itypeWord(OP_LW, 5, 1, 4));
        emit(itypeWord(OP_LW, 6, 5, 0));          // loaded base
        emit(itypeWord(OP_SW, 6, 1, 8));
        emit(itypeWord(OP_LW, 7, 1, 8));
        emit(itypeWord(OP_ADDIU, 7, 7, 1));
        emit({OP_HALT, 26'd0});
        runTest("memory access");

        // branches resolve in decode with no delay slot
        clearProgram();
        emit(itypeWord(OP_ADDIU, 1, 0, 3));
        emit(itypeWord(OP_ADDIU, 2, 0, 3));
        emit(itypeWord(OP_BEQ, 2, 1, 2));         // taken to 5
        emit(itypeWord(OP_ADDIU, 3, 0, 111));
        emit(itypeWord(OP_ADDIU, 3, 0, 222));
        emit(itypeWord(OP_ADDIU, 4, 0, 1));
        emit(itypeWord(OP_BNE, 0, 4, 1));         // waits on EX then taken to 8
        emit(itypeWord(OP_ADDIU, 5, 0, 333));
        emit(itypeWord(OP_BEQ, 0, 4, 1));         // not taken
        emit(itypeWord(OP_ADDIU, 6, 0, 4));
        emit(itypeWord(OP_BNE, 6, 6, 1));         // not taken
        emit(itypeWord(OP_ADDIU, 7, 0, 5));
        emit(jumpWord(14));
        emit(itypeWord(OP_ADDIU, 8, 0, 666));
        emit(itypeWord(OP_LW, 9, 0, 0));
        emit(itypeWord(OP_BEQ, 0, 9, 1));         // depends on load and is taken to 17
        emit(itypeWord(OP_ADDIU, 10, 0, 1));
        emit(itypeWord(OP_ADDIU, 11, 0, 3));
        emit(itypeWord(OP_ADDIU, 12, 12, 2));     // loop body
        emit(itypeWord(OP_ADDIU, 11, 11, -1));
        emit(itypeWord(OP_BNE, 0, 11, -3));
        emit({OP_HALT, 26'd0});
        runTest("control flow");

        // $zero writes stay hidden and nothing after halt retires
        clearProgram();
        emit(itypeWord(OP_ADDIU, 0, 0, 55));
        emit(itypeWord(OP_ADDIU, 1, 0, 9));
        emit(rtypeWord(F_ADDU, 0, 1, 1, 0));
        emit(rtypeWord(F_ADDU, 2, 0, 1, 0));
        emit({OP_HALT, 26'd0});
        emit(itypeWord(OP_ADDIU, 3, 0, 1));
        emit(itypeWord(OP_ADDIU, 4, 0, 2));
        runTest("register zero and halt");

        repeat (3) begin
            buildRandom(40);
            runTest("random program");
        end

        // second load after o_end sees fresh memory
        clearProgram();
        emit(itypeWord(OP_ADDIU, 1, 0, 'h77));
        emit(itypeWord(OP_LW, 2, 0, 'h40));
        emit(rtypeWord(F_OR, 3, 1, 2, 0));
        emit({OP_HALT, 26'd0});
        runTest("reload");

        $display("tests passed: %0d, failed: %0d, errors: %0d", passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
